//--- verilog/spi_slave_pkg.sv
package spi_slave_pkg;

  // command field length, shifted in msb first
  localparam int ctrl_width = 8;

  // register address length
  localparam int addr_width = 8;

  // frame state machine
  // ctrl and addr are the header, write and read the burst body
  typedef enum logic [2:0] {
    st_ctrl,
    st_addr,
    st_write,
    st_read,
    st_stop
  } spi_state_t;

  // opcodes seen in the command field
  // anything else is unknown and drops the frame
  typedef enum logic [ctrl_width-1:0] {
    cmd_write = 8'h3a,
    cmd_read  = 8'h3b
  } spi_cmd_t;

endpackage

//--- verilog/spi_frame_if.sv
interface spi_frame_if
  import spi_slave_pkg::*;
#(
  parameter int DATA_WIDTH = 24
) ();

  // events, one clock wide
  logic                          frame_end;
  logic                          word_done;
  logic                          tx_fetch;

  // received word, valid with word_done
  logic [DATA_WIDTH-1:0]         word;

  // header fields, valid while frame_end is high
  spi_cmd_t                      cmd;
  logic [addr_width-1:0]         addr;

  // read burst state for the miso mux
  logic                          reading;
  // 0 is the msb of the word in flight
  logic [$clog2(DATA_WIDTH)-1:0] bit_index;

  modport ctrl_side (
    output frame_end, word_done, tx_fetch, word, cmd, addr, reading, bit_index
  );

  modport host_side (
    input frame_end, word_done, tx_fetch, word, cmd, addr, reading, bit_index
  );

endinterface

//--- verilog/spi_pin_sync.sv
module spi_pin_sync #(
  parameter bit CPOL     = 1'b0,
  parameter bit CPHA     = 1'b0,
  parameter bit CE_LEVEL = 1'b0
) (
  input  logic clock,
  input  logic reset,
  input  logic sclk,
  input  logic ce,
  input  logic mosi,
  output logic sample,
  output logic ce_active,
  output logic mosi_bit
);

  // modes 0 and 3 sample on the rising edge, 1 and 2 on the falling one
  localparam bit sample_rise = !(CPOL ^ CPHA);

  logic sclk_meta;
  logic sclk_sync;
  logic sclk_last;
  logic ce_q;

  // two flops for sclk, a third one only for edge detection
  // idle level on reset so no false edge comes out of reset
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sclk_meta <= CPOL;
      sclk_sync <= CPOL;
      sclk_last <= CPOL;
      ce_q      <= !CE_LEVEL;
      mosi_bit  <= 1'b0;
    end else begin
      sclk_meta <= sclk;
      sclk_sync <= sclk_meta;
      sclk_last <= sclk_sync;
      // ce and mosi are stable long before the sample edge shows up
      ce_q      <= ce;
      mosi_bit  <= mosi;
    end
  end

  // single pulse per sample edge
  assign sample = sample_rise ? (sclk_sync & ~sclk_last) : (~sclk_sync & sclk_last);

  assign ce_active = (ce_q == CE_LEVEL);

endmodule

//--- verilog/spi_frame_ctrl.sv
module spi_frame_ctrl
  import spi_slave_pkg::*;
#(
  parameter int DATA_WIDTH = 24,
  parameter int LEN_WIDTH  = 32
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 sample,
  input  logic                 ce_active,
  input  logic                 mosi_bit,
  input  logic [LEN_WIDTH-1:0] burst_len,
  spi_frame_if.ctrl_side       frame
);

  // one bit counter for every field, sized for the data word
  localparam int idx_width = $clog2(DATA_WIDTH);

  spi_state_t              state;
  spi_state_t              state_next;
  logic [idx_width-1:0]    bit_cnt;
  logic [LEN_WIDTH-1:0]    word_cnt;
  logic [ctrl_width-1:0]   cmd_sr;
  logic [addr_width-1:0]   addr_sr;
  logic [DATA_WIDTH-1:0]   data_sr;
  spi_cmd_t                cmd_seen;

  logic in_data;
  logic ctrl_last;
  logic addr_last;
  logic word_last;
  logic burst_last;
  logic field_last;

  assign cmd_seen = spi_cmd_t'(cmd_sr);

  // last bit of each field
  assign in_data    = (state == st_write) || (state == st_read);
  assign ctrl_last  = (state == st_ctrl) && (bit_cnt == idx_width'(ctrl_width - 1));
  assign addr_last  = (state == st_addr) && (bit_cnt == idx_width'(addr_width - 1));
  assign word_last  = in_data && (bit_cnt == idx_width'(DATA_WIDTH - 1));
  assign burst_last = (word_cnt == burst_len - 1'b1);
  assign field_last = ctrl_last || addr_last || word_last;

  // next state, moves only on a sample pulse except out of st_stop
  always_comb begin
    state_next = state;
    if (!ce_active) begin
      // ce dropped, frame is gone
      state_next = st_ctrl;
    end else begin
      case (state)
        st_ctrl: begin
          if (sample && ctrl_last) state_next = st_addr;
        end
        st_addr: begin
          if (sample && addr_last) begin
            case (cmd_seen)
              cmd_write: state_next = st_write;
              cmd_read:  state_next = st_read;
              // unknown opcode, wait for a new command
              default:   state_next = st_ctrl;
            endcase
          end
        end
        st_write, st_read: begin
          if (sample && word_last && burst_last) state_next = st_stop;
        end
        default: state_next = st_ctrl;
      endcase
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= st_ctrl;
    end else begin
      state <= state_next;
    end
  end

  // bit position in the field, word position in the burst
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      bit_cnt  <= '0;
      word_cnt <= '0;
    end else if (!ce_active || state == st_stop) begin
      bit_cnt  <= '0;
      word_cnt <= '0;
    end else if (sample) begin
      if (field_last) begin
        bit_cnt <= '0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
      if (word_last) begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  // mosi shifters, msb first
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      cmd_sr  <= '0;
      addr_sr <= '0;
      data_sr <= '0;
    end else if (!ce_active) begin
      cmd_sr  <= '0;
      addr_sr <= '0;
      data_sr <= '0;
    end else if (sample) begin
      case (state)
        st_ctrl:  cmd_sr  <= {cmd_sr[ctrl_width-2:0], mosi_bit};
        st_addr:  addr_sr <= {addr_sr[addr_width-2:0], mosi_bit};
        st_write: data_sr <= {data_sr[DATA_WIDTH-2:0], mosi_bit};
        default:  data_sr <= data_sr;
      endcase
    end
  end

  // write word is complete on its last sample, bit taken straight from mosi
  assign frame.word_done = sample && ce_active && (state == st_write) && word_last;
  assign frame.word      = {data_sr[DATA_WIDTH-2:0], mosi_bit};

  // first read word is asked for at the end of the header,
  // the rest at the end of each word but the last
  assign frame.tx_fetch = sample && ce_active &&
                          ((addr_last && cmd_seen == cmd_read) ||
                           ((state == st_read) && word_last && !burst_last));

  assign frame.frame_end = (state == st_stop);
  assign frame.cmd       = cmd_seen;
  assign frame.addr      = addr_sr;
  assign frame.reading   = (state == st_read) && ce_active;
  assign frame.bit_index = bit_cnt;

endmodule

//--- verilog/spi_host_port.sv
module spi_host_port
  import spi_slave_pkg::*;
#(
  parameter int DATA_WIDTH = 24
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [DATA_WIDTH-1:0] tx_data,
  spi_frame_if.host_side        frame,
  output spi_cmd_t              ctrl,
  output logic [addr_width-1:0] address,
  output logic                  tx_en,
  output logic                  rx_en,
  output logic [DATA_WIDTH-1:0] rx_data,
  output logic                  spi_done,
  output logic                  miso
);

  // receive side
  // word is held until the next one completes
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rx_en   <= 1'b0;
      rx_data <= '0;
    end else begin
      rx_en <= frame.word_done;
      if (frame.word_done) begin
        rx_data <= frame.word;
      end
    end
  end

  // header fields only move on a completed frame
  // aborted or unknown frames leave them alone
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      spi_done <= 1'b0;
      ctrl     <= spi_cmd_t'('0);
      address  <= '0;
    end else begin
      spi_done <= frame.frame_end;
      if (frame.frame_end) begin
        ctrl    <= frame.cmd;
        address <= frame.addr;
      end
    end
  end

  // host has until the next toggle edge to update tx_data
  assign tx_en = frame.tx_fetch;

  // msb first out of the word the host is holding
  assign miso = frame.reading ? tx_data[DATA_WIDTH - 1 - frame.bit_index] : 1'b0;

endmodule

//--- verilog/spi_slave.sv
module spi_slave
  import spi_slave_pkg::*;
#(
  parameter int DATA_WIDTH = 24,
  parameter int LEN_WIDTH  = 32,
  parameter bit CPOL       = 1'b0,
  parameter bit CPHA       = 1'b0,
  parameter bit CE_LEVEL   = 1'b0
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [LEN_WIDTH-1:0]  burst_len,
  input  logic [DATA_WIDTH-1:0] tx_data,
  input  logic                  sclk,
  input  logic                  ce,
  input  logic                  mosi,
  output spi_cmd_t              ctrl,
  output logic [addr_width-1:0] address,
  output logic                  tx_en,
  output logic                  rx_en,
  output logic [DATA_WIDTH-1:0] rx_data,
  output logic                  spi_done,
  output logic                  miso
);

  logic sample;
  logic ce_active;
  logic mosi_bit;

  // frame events from the state machine to the host registers
  spi_frame_if #(.DATA_WIDTH(DATA_WIDTH)) frame_i ();

  // pins into the clock domain
  spi_pin_sync #(
    .CPOL     (CPOL),
    .CPHA     (CPHA),
    .CE_LEVEL (CE_LEVEL)
  ) pin_sync_i (
    .clock     (clock),
    .reset     (reset),
    .sclk      (sclk),
    .ce        (ce),
    .mosi      (mosi),
    .sample    (sample),
    .ce_active (ce_active),
    .mosi_bit  (mosi_bit)
  );

  spi_frame_ctrl #(
    .DATA_WIDTH (DATA_WIDTH),
    .LEN_WIDTH  (LEN_WIDTH)
  ) frame_ctrl_i (
    .clock     (clock),
    .reset     (reset),
    .sample    (sample),
    .ce_active (ce_active),
    .mosi_bit  (mosi_bit),
    .burst_len (burst_len),
    .frame     (frame_i.ctrl_side)
  );

  spi_host_port #(
    .DATA_WIDTH (DATA_WIDTH)
  ) host_port_i (
    .clock    (clock),
    .reset    (reset),
    .tx_data  (tx_data),
    .frame    (frame_i.host_side),
    .ctrl     (ctrl),
    .address  (address),
    .tx_en    (tx_en),
    .rx_en    (rx_en),
    .rx_data  (rx_data),
    .spi_done (spi_done),
    .miso     (miso)
  );

endmodule

//--- test/spi_slave_assert.sv
module spi_slave_assert #(
  parameter bit CE_LEVEL = 1'b0
) (
  input logic clock,
  input logic reset,
  input logic ce,
  input logic rx_en,
  input logic tx_en,
  input logic spi_done,
  input logic miso
);

  // host strobes are single cycle pulses
  rx_single: assert property (@(posedge clock) disable iff (reset) rx_en |=> !rx_en)
    else $error("rx_en stayed high for two cycles");

  tx_single: assert property (@(posedge clock) disable iff (reset) tx_en |=> !tx_en)
    else $error("tx_en stayed high for two cycles");

  done_single: assert property (@(posedge clock) disable iff (reset) spi_done |=> !spi_done)
    else $error("spi_done stayed high for two cycles");

  // ce passes one flop before it reaches the miso mux
  miso_idle: assert property (@(posedge clock) disable iff (reset)
    (ce != CE_LEVEL) && ($past(ce) != CE_LEVEL) |-> !miso)
    else $error("miso driven while ce inactive");

endmodule

//--- test/spi_slave_tb.sv
module spi_slave_tb
  import spi_slave_pkg::*;
();

  localparam int data_width = 24;
  // sclk half period in system clocks
  localparam int half_sclk  = 8;
  localparam int hdr_bits   = ctrl_width + addr_width;
  // single write, burst of 4, read of 3, abort plus burst, unknown plus write
  localparam int total_bits = 40 + 112 + 88 + (52 + 112) + (40 + 40);
  localparam int watchdog_cycles = total_bits * half_sclk * 2 * 2 + 1000;

  logic                  clock = 1'b0;
  logic                  reset;
  logic [31:0]           burst_len;
  logic [data_width-1:0] tx_data;
  logic                  sclk;
  logic                  ce;
  logic                  mosi;
  spi_cmd_t              ctrl;
  logic [addr_width-1:0] address;
  logic                  tx_en;
  logic                  rx_en;
  logic [data_width-1:0] rx_data;
  logic                  spi_done;
  logic                  miso;

  int                    errors;
  int                    done_count;
  int                    tx_count;
  // words seen on rx_data, words queued for tx_data
  logic [data_width-1:0] rx_seen[$];
  logic [data_width-1:0] tx_words[$];
  // mosi payload of the next frame, miso words of the last one
  logic [data_width-1:0] wr_words[$];
  logic [data_width-1:0] rd_seen[$];

  spi_slave spi_slave_i (.*);

  bind spi_slave spi_slave_assert #(.CE_LEVEL(CE_LEVEL)) checks_i (
    .clock(clock), .reset(reset), .ce(ce), .rx_en(rx_en),
    .tx_en(tx_en), .spi_done(spi_done), .miso(miso)
  );

  always #50 clock = ~clock;

  // host side, looked at once per clock after the edge settles
  initial begin
    tx_data    = '0;
    done_count = 0;
    tx_count   = 0;
    forever begin
      @(posedge clock);
      #10;
      if (rx_en) rx_seen.push_back(rx_data);
      if (spi_done) done_count++;
      if (tx_en) begin
        // next queued read word, zero if none left
        tx_data = (tx_count < tx_words.size()) ? tx_words[tx_count] : '0;
        tx_count++;
      end
    end
  end

  task automatic tick(input int n);
    repeat (n) @(posedge clock);
    #10;
  endtask

  // mode 0 bit, mosi set while sclk low, miso taken just before the rise
  task automatic xfer_bit(input logic b, output logic got);
    mosi = b;
    tick(half_sclk);
    got  = miso;
    sclk = 1'b1;
    tick(half_sclk);
    sclk = 1'b0;
  endtask

  // whole frame, cut short after max_bits if that is nonzero
  task automatic run_frame(input logic [ctrl_width-1:0] op, input logic [addr_width-1:0] adr,
                           input int nwords, input int max_bits);
    logic [hdr_bits-1:0]   hdr;
    logic [data_width-1:0] word;
    logic [data_width-1:0] rd_word;
    logic                  b;
    logic                  got;
    int                    n;
    int                    w;
    int                    pos;
    n = hdr_bits + nwords * data_width;
    if (max_bits > 0 && max_bits < n) n = max_bits;
    hdr     = {op, adr};
    word    = '0;
    rd_word = '0;
    pos     = 0;
    rd_seen.delete();
    ce = 1'b0;
    tick(half_sclk);
    for (int i = 0; i < n; i++) begin
      if (i < hdr_bits) begin
        b   = hdr[hdr_bits-1];
        hdr = hdr << 1;
      end else begin
        pos = (i - hdr_bits) % data_width;
        w   = (i - hdr_bits) / data_width;
        // read frames shift zeros on mosi
        if (pos == 0) word = (w < wr_words.size()) ? wr_words[w] : '0;
        b    = word[data_width-1];
        word = word << 1;
      end
      xfer_bit(b, got);
      if (i >= hdr_bits) begin
        rd_word = {rd_word[data_width-2:0], got};
        if (pos == data_width - 1) rd_seen.push_back(rd_word);
      end
    end
    tick(half_sclk);
    ce = 1'b1;
    tick(half_sclk);
  endtask

  task automatic check_cmd(input string name, input spi_cmd_t exp, input spi_cmd_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input logic [addr_width-1:0] exp,
                            input logic [addr_width-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input logic [data_width-1:0] exp,
                            input logic [data_width-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_pulses(input string name, input int exp, input int act);
    if (act != exp) begin
      errors++;
      $display("%s pulsed %0d times where %0d pulses were expected", name, act, exp);
    end
  endtask

  // write frame of n random words, every word and the header checked
  task automatic write_burst(input int n);
    logic [addr_width-1:0] adr;
    int                    rx0;
    int                    done0;
    adr   = addr_width'($urandom);
    rx0   = rx_seen.size();
    done0 = done_count;
    wr_words.delete();
    repeat (n) wr_words.push_back(data_width'($urandom));
    burst_len = n;
    run_frame(cmd_write, adr, n, 0);
    check_pulses("rx_en", n, rx_seen.size() - rx0);
    for (int i = 0; i < n && rx0 + i < rx_seen.size(); i++)
      check_word("rx_data", wr_words[i], rx_seen[rx0 + i]);
    check_pulses("spi_done", 1, done_count - done0);
    check_cmd("ctrl", cmd_write, ctrl);
    check_addr("address", adr, address);
  endtask

  task automatic read_burst();
    logic [addr_width-1:0] adr;
    int                    tx0;
    int                    done0;
    adr   = addr_width'($urandom);
    tx0   = tx_count;
    done0 = done_count;
    wr_words.delete();
    // handed out in order, one per tx_en
    repeat (3) tx_words.push_back(data_width'($urandom));
    burst_len = 3;
    run_frame(cmd_read, adr, 3, 0);
    check_pulses("tx_en", 3, tx_count - tx0);
    for (int i = 0; i < 3 && i < rd_seen.size(); i++)
      check_word("miso", tx_words[tx0 + i], rd_seen[i]);
    check_pulses("spi_done", 1, done_count - done0);
    check_cmd("ctrl", cmd_read, ctrl);
    check_addr("address", adr, address);
    // ce is inactive again
    check_bit("miso", 1'b0, miso);
  endtask

  task automatic unknown_opcode();
    int rx0;
    int done0;
    rx0   = rx_seen.size();
    done0 = done_count;
    wr_words.delete();
    burst_len = 1;
    // one word of zeros after the header, enough to finish a burst of 1
    // if the opcode were taken as a write or a read
    run_frame(8'h55, addr_width'($urandom), 1, 0);
    check_pulses("rx_en", 0, rx_seen.size() - rx0);
    check_pulses("spi_done", 0, done_count - done0);
    write_burst(1);
  endtask

  task automatic abort_write();
    spi_cmd_t              ctrl_before;
    logic [addr_width-1:0] addr_before;
    int                    rx0;
    int                    done0;
    ctrl_before = ctrl;
    addr_before = address;
    rx0         = rx_seen.size();
    done0       = done_count;
    wr_words.delete();
    repeat (4) wr_words.push_back(data_width'($urandom));
    burst_len = 4;
    // header, one full word, then half of the second
    // address differs from the latched one in every bit
    run_frame(cmd_write, ~addr_before, 4, hdr_bits + data_width + data_width / 2);
    check_pulses("rx_en", 1, rx_seen.size() - rx0);
    if (rx_seen.size() > rx0) check_word("rx_data", wr_words[0], rx_seen[rx0]);
    check_pulses("spi_done", 0, done_count - done0);
    check_cmd("ctrl", ctrl_before, ctrl);
    check_addr("address", addr_before, address);
    write_burst(4);
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("timeout, tests still running after %0d clocks", watchdog_cycles);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    int first_draw;
    first_draw = $urandom(32'h9865_3ad3);
    errors    = 0;
    reset     = 1'b1;
    burst_len = '0;
    sclk      = 1'b0;
    ce        = 1'b1;
    mosi      = 1'b0;
    tick(4);
    reset = 1'b0;
    tick(4);
    write_burst(1);
    write_burst(4);
    read_burst();
    // abort right after the read so the held ctrl differs from cmd_write
    abort_write();
    unknown_opcode();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
verilog/spi_slave_pkg.sv
verilog/spi_frame_if.sv
verilog/spi_pin_sync.sv
verilog/spi_frame_ctrl.sv
verilog/spi_host_port.sv
verilog/spi_slave.sv
test/spi_slave_assert.sv
test/spi_slave_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f verilog.f --top-module spi_slave_tb -o spi_slave_sim

out=$(./obj_dir/spi_slave_sim)
echo "$out"

if grep -qx "Result: PASSED" <<< "$out"; then
  exit 0
else
  exit 1
fi
